// File: src/sdram_map_pkg.sv
/* SDRAM slot mapper shared definitions
   Region offsets, data widths, slot indices and arbiter states */
package sdram_map_pkg;

    typedef logic [22:0] sdram_addr_t;   // SDRAM word address
    typedef logic [31:0] sdram_data_t;   // Full word from the bank
    typedef logic [15:0] half_t;
    typedef logic [7:0]  byte_t;
    typedef logic [1:0]  wrmask_t;       // Active low, bit 1 is the upper byte
    typedef logic [1:0]  slot_id_t;
    typedef logic [3:0]  slot_vec_t;     // One bit per slot

    localparam int NUM_SLOTS = 4;

    // Lower index wins arbitration
    localparam slot_id_t SLOT_RAM = 2'd0;  // Work RAM and VRAM
    localparam slot_id_t SLOT_ROM = 2'd1;  // Main CPU ROM
    localparam slot_id_t SLOT_SND = 2'd2;  // Sound CPU ROM
    localparam slot_id_t SLOT_GFX = 2'd3;  // Graphics ROM

    // Region base addresses in SDRAM words
    localparam sdram_addr_t ROM_OFFSET  = 23'h00_0000;
    localparam sdram_addr_t VRAM_OFFSET = 23'h20_0000;
    localparam sdram_addr_t WRAM_OFFSET = 23'h30_0000;
    localparam sdram_addr_t SND_OFFSET  = 23'h38_0000;
    localparam sdram_addr_t GFX_OFFSET  = 23'h40_0000;

    typedef enum logic [1:0] {
        IDLE,       // Looking for a pending slot
        REQ,        // rd or wr held until ack
        WAIT_RDY    // Bank accepted, waiting for data
    } arb_state_t;

endpackage

// File: src/slot_req_if.sv
/* Per-slot request bundle from the decoder to the arbiter and the return stage */
`timescale 1ns/1ns

interface slot_req_if;

    sdram_map_pkg::sdram_addr_t [sdram_map_pkg::NUM_SLOTS-1:0] addr;  // Offset already added
    sdram_map_pkg::slot_vec_t need_cs;
    logic                     byte_sel;  // Sound byte within the word
    logic                     ram_wr;
    sdram_map_pkg::half_t     ram_din;
    sdram_map_pkg::wrmask_t   ram_mask;

    modport dec (
        output addr, need_cs, byte_sel, ram_wr, ram_din, ram_mask
    );

    modport arb (
        input addr, need_cs, ram_wr, ram_din, ram_mask
    );

    modport ret (
        input addr, need_cs, byte_sel, ram_wr
    );

endinterface

// File: src/region_decode.sv
/* Client address decode
   Maps each client select and address onto its SDRAM region */
`timescale 1ns/1ns

module region_decode (
    input  logic                   main_ram_cs,
    input  logic                   main_vram_cs,
    input  logic                   main_rom_cs,
    input  logic                   snd_cs,
    input  logic                   gfx_cs,
    input  logic [16:0]            main_ram_addr,  // Word address
    input  logic                   main_rnw,
    input  sdram_map_pkg::half_t   main_dout,
    input  sdram_map_pkg::wrmask_t dsn,
    input  logic [20:0]            main_rom_addr,
    input  logic [15:0]            snd_addr,       // Byte address
    input  logic [19:0]            gfx_addr,
    input  logic                   gfx_half,
    slot_req_if.dec                req
);

    logic                        ram_vram_cs;
    sdram_map_pkg::sdram_addr_t  ram_offset;
    sdram_map_pkg::sdram_addr_t  ram_word;
    sdram_map_pkg::sdram_addr_t  rom_word;
    sdram_map_pkg::sdram_addr_t  snd_word;
    sdram_map_pkg::sdram_addr_t  gfx_word;

    assign ram_vram_cs = main_ram_cs | main_vram_cs;
    assign ram_offset  = main_ram_cs ? sdram_map_pkg::WRAM_OFFSET
                                     : sdram_map_pkg::VRAM_OFFSET;

    // Zero-extend each client address to the SDRAM width
    assign ram_word = {6'd0, main_ram_addr};
    assign rom_word = {2'd0, main_rom_addr};
    assign snd_word = {8'd0, snd_addr[15:1]};       // Bytes to words
    assign gfx_word = {2'd0, gfx_addr, gfx_half};   // Half picks the odd word

    assign req.addr[sdram_map_pkg::SLOT_RAM] = ram_word + ram_offset;
    assign req.addr[sdram_map_pkg::SLOT_ROM] = rom_word + sdram_map_pkg::ROM_OFFSET;
    assign req.addr[sdram_map_pkg::SLOT_SND] = snd_word + sdram_map_pkg::SND_OFFSET;
    assign req.addr[sdram_map_pkg::SLOT_GFX] = gfx_word + sdram_map_pkg::GFX_OFFSET;

    assign req.need_cs = {gfx_cs, snd_cs, main_rom_cs, ram_vram_cs};
    assign req.byte_sel = snd_addr[0];

    // Only the RAM slot can write
    assign req.ram_wr   = ram_vram_cs & ~main_rnw;
    assign req.ram_din  = main_dout;
    assign req.ram_mask = dsn;

    // Both regions share slot 0 and one offset mux
    always_comb begin
        assert (!(main_ram_cs && main_vram_cs))
            else $error("region_decode: RAM and VRAM selected together");
    end

endmodule

// File: src/slot_arbiter.sv
/* Fixed-priority SDRAM slot arbiter
   Grants one pending slot at a time and holds rd/wr until the bank acks */
`timescale 1ns/1ns

module slot_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    slot_req_if.arb                    req,
    input  sdram_map_pkg::slot_vec_t   hit,
    input  logic                       sdram_ack,
    input  logic                       data_rdy,
    output sdram_map_pkg::sdram_addr_t sdram_addr,
    output logic                       sdram_rd,
    output logic                       sdram_wr,
    output sdram_map_pkg::half_t       sdram_din,
    output sdram_map_pkg::wrmask_t     sdram_wrmask,
    output logic                       done,
    output sdram_map_pkg::slot_id_t    done_slot,
    output logic                       done_wr
);

    sdram_map_pkg::arb_state_t state;
    sdram_map_pkg::slot_vec_t  pending;
    sdram_map_pkg::slot_vec_t  done_mask;
    sdram_map_pkg::slot_id_t   grant;
    sdram_map_pkg::slot_id_t   cur_slot;
    logic                      grant_wr;
    logic                      cur_wr;
    logic                      start;

    // Lowest set bit wins
    function automatic sdram_map_pkg::slot_id_t first_set(input sdram_map_pkg::slot_vec_t v);
        sdram_map_pkg::slot_id_t idx;
        idx = sdram_map_pkg::SLOT_RAM;
        for (int i = sdram_map_pkg::NUM_SLOTS - 1; i >= 0; i--) begin
            if (v[i]) idx = sdram_map_pkg::slot_id_t'(i);
        end
        return idx;
    endfunction

    // The finished slot is not cached yet while done is high
    assign done_mask = done ? (sdram_map_pkg::slot_vec_t'(1) << done_slot) : '0;
    assign pending   = req.need_cs & ~hit & ~done_mask;
    assign grant     = first_set(pending);
    assign grant_wr  = (grant == sdram_map_pkg::SLOT_RAM) && req.ram_wr;
    assign start     = (state == sdram_map_pkg::IDLE) && (|pending);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= sdram_map_pkg::IDLE;
            sdram_rd <= 1'b0;
            sdram_wr <= 1'b0;
            done     <= 1'b0;
            cur_slot <= sdram_map_pkg::SLOT_RAM;
            cur_wr   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                sdram_map_pkg::IDLE: begin
                    if (start) begin
                        cur_slot <= grant;
                        cur_wr   <= grant_wr;
                        sdram_rd <= ~grant_wr;
                        sdram_wr <= grant_wr;
                        state    <= sdram_map_pkg::REQ;
                    end
                end
                sdram_map_pkg::REQ: begin
                    if (sdram_ack) begin   // Bank took it, release the request
                        sdram_rd <= 1'b0;
                        sdram_wr <= 1'b0;
                        state    <= sdram_map_pkg::WAIT_RDY;
                    end
                end
                sdram_map_pkg::WAIT_RDY: begin
                    if (data_rdy) begin
                        done  <= 1'b1;
                        state <= sdram_map_pkg::IDLE;
                    end
                end
                default: state <= sdram_map_pkg::IDLE;
            endcase
        end
    end

    // Request payload, frozen from grant until the next one
    always_ff @(posedge clk) begin
        if (start) begin
            sdram_addr   <= req.addr[grant];
            sdram_din    <= req.ram_din;
            sdram_wrmask <= req.ram_mask;
        end
    end

    assign done_slot = cur_slot;   // Stable until the next grant
    assign done_wr   = cur_wr;

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(sdram_rd && sdram_wr))
        else $error("slot_arbiter: rd and wr high together");

    // Bank may sample any cycle before ack
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (sdram_rd || sdram_wr) && !sdram_ack |=>
            $stable({sdram_rd, sdram_wr, sdram_addr, sdram_din, sdram_wrmask}))
        else $error("slot_arbiter: request changed before ack");

endmodule

// File: src/slot_return.sv
/* Slot data return
   Per-slot data latches and address cache driving the client ok levels */
`timescale 1ns/1ns

module slot_return (
    input  logic                       clk,
    input  logic                       rst,
    slot_req_if.ret                    req,
    input  logic                       done,
    input  sdram_map_pkg::slot_id_t    done_slot,
    input  logic                       done_wr,
    input  sdram_map_pkg::sdram_data_t data_read,
    output sdram_map_pkg::slot_vec_t   hit,
    output logic                       ram_ok,
    output logic                       rom_ok,
    output logic                       snd_ok,
    output logic                       gfx_ok,
    output sdram_map_pkg::half_t       ram_data,
    output sdram_map_pkg::half_t       rom_data,
    output sdram_map_pkg::byte_t       snd_data,
    output sdram_map_pkg::sdram_data_t gfx_data
);

    sdram_map_pkg::slot_vec_t  valid;
    sdram_map_pkg::sdram_addr_t [sdram_map_pkg::NUM_SLOTS-1:0] cache_addr;
    logic                      ram_wr_flag;   // Slot 0 entry came from a write
    sdram_map_pkg::sdram_data_t rdy_data;     // Word seen on the rdy cycle
    sdram_map_pkg::half_t      ram_q;
    sdram_map_pkg::half_t      rom_q;
    sdram_map_pkg::half_t      snd_q;         // Both bytes kept
    sdram_map_pkg::sdram_data_t gfx_q;

    // done trails rdy by one cycle
    always_ff @(posedge clk) begin
        rdy_data <= data_read;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid       <= '0;
            ram_wr_flag <= 1'b0;
        end else if (done) begin
            valid[done_slot] <= 1'b1;
            if (done_slot == sdram_map_pkg::SLOT_RAM) ram_wr_flag <= done_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            cache_addr[done_slot] <= req.addr[done_slot];
            case (done_slot)
                sdram_map_pkg::SLOT_RAM: if (!done_wr) ram_q <= rdy_data[15:0];
                sdram_map_pkg::SLOT_ROM: rom_q <= rdy_data[15:0];
                sdram_map_pkg::SLOT_SND: snd_q <= rdy_data[15:0];
                default:                 gfx_q <= rdy_data;
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < sdram_map_pkg::NUM_SLOTS; i++) begin
            hit[i] = valid[i] && (cache_addr[i] == req.addr[i]);
        end
        // A read after a write to the same word must go back to the bank
        hit[sdram_map_pkg::SLOT_RAM] = hit[sdram_map_pkg::SLOT_RAM] &&
                                       (ram_wr_flag == req.ram_wr);
    end

    assign ram_ok = req.need_cs[sdram_map_pkg::SLOT_RAM] & hit[sdram_map_pkg::SLOT_RAM];
    assign rom_ok = req.need_cs[sdram_map_pkg::SLOT_ROM] & hit[sdram_map_pkg::SLOT_ROM];
    assign snd_ok = req.need_cs[sdram_map_pkg::SLOT_SND] & hit[sdram_map_pkg::SLOT_SND];
    assign gfx_ok = req.need_cs[sdram_map_pkg::SLOT_GFX] & hit[sdram_map_pkg::SLOT_GFX];

    assign ram_data = ram_q;
    assign rom_data = rom_q;
    assign snd_data = req.byte_sel ? snd_q[15:8] : snd_q[7:0];   // Odd byte is the upper one
    assign gfx_data = gfx_q;

    // Clients keep cs up until ok, so a done can't arrive unrequested
    a_done_cs: assert property (@(posedge clk) disable iff (rst)
        done |-> req.need_cs[done_slot])
        else $error("slot_return: done for a slot without select");

endmodule

// File: src/sdram_slots.sv
/* SDRAM slot mapper top level
   Four client ports sharing one SDRAM bank port */
`timescale 1ns/1ns

module sdram_slots (
    input  logic                       clk,
    input  logic                       rst,

    // Main CPU RAM and VRAM
    input  logic                       main_ram_cs,
    input  logic                       main_vram_cs,
    input  logic [16:0]                main_ram_addr,
    input  logic                       main_rnw,
    input  sdram_map_pkg::half_t       main_dout,
    input  sdram_map_pkg::wrmask_t     dsn,
    output logic                       ram_ok,
    output sdram_map_pkg::half_t       ram_data,

    // Main CPU ROM
    input  logic                       main_rom_cs,
    input  logic [20:0]                main_rom_addr,
    output logic                       rom_ok,
    output sdram_map_pkg::half_t       rom_data,

    // Sound CPU ROM
    input  logic                       snd_cs,
    input  logic [15:0]                snd_addr,
    output logic                       snd_ok,
    output sdram_map_pkg::byte_t       snd_data,

    // Graphics ROM
    input  logic                       gfx_cs,
    input  logic [19:0]                gfx_addr,
    input  logic                       gfx_half,
    output logic                       gfx_ok,
    output sdram_map_pkg::sdram_data_t gfx_data,

    // SDRAM bank
    output sdram_map_pkg::sdram_addr_t sdram_addr,
    output logic                       sdram_rd,
    output logic                       sdram_wr,
    output sdram_map_pkg::half_t       sdram_din,
    output sdram_map_pkg::wrmask_t     sdram_wrmask,
    input  logic                       sdram_ack,
    input  logic                       data_rdy,
    input  sdram_map_pkg::sdram_data_t data_read
);

    slot_req_if                req ();
    sdram_map_pkg::slot_vec_t  hit;
    logic                      done;
    sdram_map_pkg::slot_id_t   done_slot;
    logic                      done_wr;

    region_decode i_decode (
        .main_ram_cs   (main_ram_cs),
        .main_vram_cs  (main_vram_cs),
        .main_rom_cs   (main_rom_cs),
        .snd_cs        (snd_cs),
        .gfx_cs        (gfx_cs),
        .main_ram_addr (main_ram_addr),
        .main_rnw      (main_rnw),
        .main_dout     (main_dout),
        .dsn           (dsn),
        .main_rom_addr (main_rom_addr),
        .snd_addr      (snd_addr),
        .gfx_addr      (gfx_addr),
        .gfx_half      (gfx_half),
        .req           (req.dec)
    );

    slot_arbiter i_arbiter (
        .clk          (clk),
        .rst          (rst),
        .req          (req.arb),
        .hit          (hit),
        .sdram_ack    (sdram_ack),
        .data_rdy     (data_rdy),
        .sdram_addr   (sdram_addr),
        .sdram_rd     (sdram_rd),
        .sdram_wr     (sdram_wr),
        .sdram_din    (sdram_din),
        .sdram_wrmask (sdram_wrmask),
        .done         (done),
        .done_slot    (done_slot),
        .done_wr      (done_wr)
    );

    slot_return i_return (
        .clk       (clk),
        .rst       (rst),
        .req       (req.ret),
        .done      (done),
        .done_slot (done_slot),
        .done_wr   (done_wr),
        .data_read (data_read),
        .hit       (hit),
        .ram_ok    (ram_ok),
        .rom_ok    (rom_ok),
        .snd_ok    (snd_ok),
        .gfx_ok    (gfx_ok),
        .ram_data  (ram_data),
        .rom_data  (rom_data),
        .snd_data  (snd_data),
        .gfx_data  (gfx_data)
    );

endmodule

// File: tb/sdram_bank_model.sv
/* Behavioral SDRAM bank for the slot mapper testbench
   Random ack and rdy delays over an address-derived memory pattern */
`timescale 1ns/1ns

module sdram_bank_model (
    input  logic                       clk,
    input  logic                       rst,
    input  sdram_map_pkg::sdram_addr_t sdram_addr,
    input  logic                       sdram_rd,
    input  logic                       sdram_wr,
    input  sdram_map_pkg::half_t       sdram_din,
    input  sdram_map_pkg::wrmask_t     sdram_wrmask,
    output logic                       sdram_ack,
    output logic                       data_rdy,
    output sdram_map_pkg::sdram_data_t data_read,
    input  logic                       log_clear,
    output int                         log_count,   // Requests since the last clear
    output sdram_map_pkg::sdram_addr_t log_first    // Address of the first of them
);

    sdram_map_pkg::half_t       mem [sdram_map_pkg::sdram_addr_t];  // Written low halves only
    sdram_map_pkg::sdram_addr_t cur_addr;
    sdram_map_pkg::half_t       cur_din;
    sdram_map_pkg::wrmask_t     cur_mask;
    sdram_map_pkg::half_t       low;
    logic                       cur_wr;
    logic [1:0]                 phase;   // 0 idle, 1 ack delay, 2 rdy delay
    int                         cnt;
    integer                     seed = 72997;

    // One to four cycles
    function automatic int rand_delay();
        logic [31:0] bits;
        bits = $random(seed);
        return int'(bits[1:0]) + 1;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= '0;
            phase     <= 2'd0;
            cnt       <= 0;
            log_count <= 0;
            log_first <= '0;
        end else begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            if (log_clear) begin
                log_count <= 0;
            end else if (phase == 2'd0 && (sdram_rd || sdram_wr)) begin
                if (log_count == 0) log_first <= sdram_addr;
                log_count <= log_count + 1;
            end
            case (phase)
                2'd0: begin
                    if (sdram_rd || sdram_wr) begin
                        cur_addr <= sdram_addr;
                        cur_din  <= sdram_din;
                        cur_mask <= sdram_wrmask;
                        cur_wr   <= sdram_wr;
                        cnt      <= rand_delay();
                        phase    <= 2'd1;
                    end
                end
                2'd1: begin
                    if (cnt == 1) begin
                        sdram_ack <= 1'b1;
                        cnt       <= rand_delay();
                        phase     <= 2'd2;
                    end else cnt <= cnt - 1;
                end
                default: begin
                    if (cnt == 1) begin
                        low = mem.exists(cur_addr) ? mem[cur_addr] : cur_addr[15:0];
                        if (cur_wr) begin   // Active-low byte mask
                            if (!cur_mask[1]) low[15:8] = cur_din[15:8];
                            if (!cur_mask[0]) low[7:0] = cur_din[7:0];
                            mem[cur_addr] = low;
                        end
                        data_read <= {~cur_addr[15:0], low};
                        data_rdy  <= 1'b1;
                        phase     <= 2'd0;
                    end else cnt <= cnt - 1;
                end
            endcase
        end
    end

endmodule

// File: tb/tb_sdram_slots.sv
/* Testbench for the SDRAM slot mapper
   Directed reads, writes, hold and priority checks against a shadow memory */
`timescale 1ns/1ns

module tb_sdram_slots;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       main_ram_cs;
    logic                       main_vram_cs;
    logic                       main_rom_cs;
    logic                       snd_cs;
    logic                       gfx_cs;
    logic                       main_rnw;
    logic                       gfx_half;
    logic [16:0]                main_ram_addr;
    logic [20:0]                main_rom_addr;
    logic [15:0]                snd_addr;
    logic [19:0]                gfx_addr;
    sdram_map_pkg::half_t       main_dout;
    sdram_map_pkg::wrmask_t     dsn;
    logic                       ram_ok;
    logic                       rom_ok;
    logic                       snd_ok;
    logic                       gfx_ok;
    sdram_map_pkg::half_t       ram_data;
    sdram_map_pkg::half_t       rom_data;
    sdram_map_pkg::byte_t       snd_data;
    sdram_map_pkg::sdram_data_t gfx_data;
    sdram_map_pkg::sdram_addr_t sdram_addr;
    logic                       sdram_rd;
    logic                       sdram_wr;
    sdram_map_pkg::half_t       sdram_din;
    sdram_map_pkg::wrmask_t     sdram_wrmask;
    logic                       sdram_ack;
    logic                       data_rdy;
    sdram_map_pkg::sdram_data_t data_read;
    logic                       log_clear;
    int                         log_count;
    sdram_map_pkg::sdram_addr_t log_first;
    sdram_map_pkg::slot_vec_t   ok_vec;
    sdram_map_pkg::half_t       shadow [sdram_map_pkg::sdram_addr_t];  // Written low halves
    int                         errors = 0;
    int                         timeouts = 0;

    always #4 clk = ~clk;

    assign ok_vec = {gfx_ok, snd_ok, rom_ok, ram_ok};

    sdram_slots i_dut (.*);
    sdram_bank_model i_bank (.*);

    // Low half is the address, high half its inverse
    function automatic sdram_map_pkg::sdram_data_t pattern_word(input sdram_map_pkg::sdram_addr_t a);
        sdram_map_pkg::half_t lo;
        lo = shadow.exists(a) ? shadow[a] : a[15:0];
        return {~a[15:0], lo};
    endfunction

    task automatic check_half(input string name, input sdram_map_pkg::half_t exp,
                              input sdram_map_pkg::half_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input sdram_map_pkg::byte_t exp,
                              input sdram_map_pkg::byte_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input sdram_map_pkg::sdram_data_t exp,
                              input sdram_map_pkg::sdram_data_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input sdram_map_pkg::sdram_addr_t exp,
                              input sdram_map_pkg::sdram_addr_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic drive_edge();
        @(posedge clk);
        #1;
    endtask

    // Samples on falling edges, away from the drive point
    task automatic wait_ok(input sdram_map_pkg::slot_id_t slot, input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!ok_vec[slot] && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!ok_vec[slot]) begin
            $display("%s: no ok from slot %0d within 200 cycles", name, slot);
            timeouts++;
        end
    endtask

    task automatic release_all();
        drive_edge();
        main_ram_cs  = 1'b0;
        main_vram_cs = 1'b0;
        main_rom_cs  = 1'b0;
        snd_cs       = 1'b0;
        gfx_cs       = 1'b0;
        main_rnw     = 1'b1;
        dsn          = 2'b11;
    endtask

    task automatic test_rom_gfx();
        sdram_map_pkg::sdram_data_t w;
        sdram_map_pkg::sdram_addr_t a;
        drive_edge();
        main_rom_cs   = 1'b1;
        main_rom_addr = 21'h01_2345;
        wait_ok(sdram_map_pkg::SLOT_ROM, "rom_gfx");
        a = sdram_map_pkg::ROM_OFFSET + 23'h01_2345;
        w = pattern_word(a);
        check_half("rom_gfx rom", w[15:0], rom_data);
        check_addr("rom_gfx rom address", a, sdram_addr);
        release_all();
        for (int h = 0; h < 2; h++) begin
            drive_edge();
            gfx_cs   = 1'b1;
            gfx_addr = 20'h0_5a5a;
            gfx_half = h[0];   // Odd word on the second pass
            wait_ok(sdram_map_pkg::SLOT_GFX, "rom_gfx");
            a = sdram_map_pkg::GFX_OFFSET +
                sdram_map_pkg::sdram_addr_t'({20'h0_5a5a, h[0]});
            w = pattern_word(a);
            check_word("rom_gfx gfx", w, gfx_data);
            check_addr("rom_gfx gfx address", a, sdram_addr);
        end
        release_all();
    endtask

    task automatic read_snd(input logic [15:0] a);
        sdram_map_pkg::sdram_addr_t word_addr;
        sdram_map_pkg::sdram_data_t w;
        drive_edge();
        snd_cs   = 1'b1;
        snd_addr = a;
        wait_ok(sdram_map_pkg::SLOT_SND, "snd");
        word_addr = sdram_map_pkg::SND_OFFSET + sdram_map_pkg::sdram_addr_t'(a[15:1]);
        w = pattern_word(word_addr);
        check_byte("snd", a[0] ? w[15:8] : w[7:0], snd_data);
        check_addr("snd address", word_addr, sdram_addr);
    endtask

    task automatic test_snd();
        read_snd(16'h2345);
        read_snd(16'h2344);   // Other byte of the same word
        read_snd(16'h0abd);
        release_all();
    endtask

    task automatic test_write();
        sdram_map_pkg::sdram_addr_t a;
        sdram_map_pkg::sdram_data_t w;
        sdram_map_pkg::half_t       lo;
        a = sdram_map_pkg::WRAM_OFFSET + 23'h0_0100;
        drive_edge();
        main_ram_cs   = 1'b1;
        main_ram_addr = 17'h0_0100;
        main_rnw      = 1'b0;
        main_dout     = 16'hbeef;
        dsn           = 2'b01;   // Upper byte only
        wait_ok(sdram_map_pkg::SLOT_RAM, "write");
        w  = pattern_word(a);
        lo = w[15:0];
        if (!dsn[1]) lo[15:8] = main_dout[15:8];
        if (!dsn[0]) lo[7:0] = main_dout[7:0];
        shadow[a] = lo;
        release_all();
        drive_edge();
        main_ram_cs = 1'b1;
        wait_ok(sdram_map_pkg::SLOT_RAM, "write readback");
        w = pattern_word(a);
        check_half("write readback", w[15:0], ram_data);
        release_all();
        drive_edge();
        main_vram_cs = 1'b1;
        wait_ok(sdram_map_pkg::SLOT_RAM, "write vram");
        w = pattern_word(sdram_map_pkg::VRAM_OFFSET + 23'h0_0100);
        check_half("write vram", w[15:0], ram_data);
        release_all();
    endtask

    task automatic test_hold();
        sdram_map_pkg::sdram_data_t w;
        drive_edge();
        main_rom_cs   = 1'b1;
        main_rom_addr = 21'h00_0777;
        wait_ok(sdram_map_pkg::SLOT_ROM, "hold");
        w = pattern_word(sdram_map_pkg::ROM_OFFSET + 23'h00_0777);
        repeat (10) begin
            @(negedge clk);
            if (!rom_ok) begin
                $display("hold: rom_ok dropped while cs and address were held");
                errors++;
            end
            check_half("hold", w[15:0], rom_data);
        end
        drive_edge();
        main_rom_addr = 21'h00_0778;
        @(negedge clk);
        if (rom_ok) begin
            $display("hold: rom_ok stayed high after the address changed");
            errors++;
        end
        wait_ok(sdram_map_pkg::SLOT_ROM, "hold new address");
        w = pattern_word(sdram_map_pkg::ROM_OFFSET + 23'h00_0778);
        check_half("hold new address", w[15:0], rom_data);
        release_all();
    endtask

    task automatic test_all_slots();
        sdram_map_pkg::sdram_data_t w;
        drive_edge();
        log_clear = 1'b1;
        drive_edge();
        log_clear = 1'b0;
        drive_edge();
        main_ram_cs   = 1'b1;
        main_ram_addr = 17'h0_0200;
        main_rom_cs   = 1'b1;
        main_rom_addr = 21'h00_1000;
        snd_cs        = 1'b1;
        snd_addr      = 16'h0100;
        gfx_cs        = 1'b1;
        gfx_addr      = 20'h0_0400;
        gfx_half      = 1'b0;
        wait_ok(sdram_map_pkg::SLOT_RAM, "all ram");
        wait_ok(sdram_map_pkg::SLOT_ROM, "all rom");
        wait_ok(sdram_map_pkg::SLOT_SND, "all snd");
        wait_ok(sdram_map_pkg::SLOT_GFX, "all gfx");
        w = pattern_word(sdram_map_pkg::WRAM_OFFSET + 23'h0_0200);
        check_half("all ram", w[15:0], ram_data);
        w = pattern_word(sdram_map_pkg::ROM_OFFSET + 23'h00_1000);
        check_half("all rom", w[15:0], rom_data);
        w = pattern_word(sdram_map_pkg::SND_OFFSET + 23'h00_0080);
        check_byte("all snd", w[7:0], snd_data);
        w = pattern_word(sdram_map_pkg::GFX_OFFSET + 23'h00_0800);
        check_word("all gfx", w, gfx_data);
        if (log_count != 4) begin
            $display("[ERROR] all slots request count: expected 4, got %0d", log_count);
            errors++;
        end
        check_addr("all first served", sdram_map_pkg::WRAM_OFFSET + 23'h0_0200, log_first);
        release_all();
    endtask

    initial begin
        rst           = 1'b1;
        main_ram_cs   = 1'b0;
        main_vram_cs  = 1'b0;
        main_rom_cs   = 1'b0;
        snd_cs        = 1'b0;
        gfx_cs        = 1'b0;
        main_rnw      = 1'b1;
        gfx_half      = 1'b0;
        main_ram_addr = '0;
        main_rom_addr = '0;
        snd_addr      = '0;
        gfx_addr      = '0;
        main_dout     = '0;
        dsn           = 2'b11;
        log_clear     = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        test_rom_gfx();
        test_snd();
        test_write();
        test_hold();
        test_all_slots();
        $display("Done: %0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: files.f
src/sdram_map_pkg.sv
src/slot_req_if.sv
src/region_decode.sv
src/slot_arbiter.sv
src/slot_return.sv
src/sdram_slots.sv
tb/sdram_bank_model.sv
tb/tb_sdram_slots.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the SDRAM slot mapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f files.f --top-module tb_sdram_slots -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/sim_tb 2>&1); then
    echo "$output"
    echo "Simulation exited with an error"
    exit 1
fi

echo "$output"

if grep -qF "*** TEST PASSED ***" <<< "$output"; then
    exit 0
fi

exit 1
